// ==== Makefile ====
TOP = tb_hist_saxi

all: run

build:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f src.f -Mdir obj_dir

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only --timing --top-module $(TOP) -f src.f

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

// ==== hist_axi_pkg.sv ====
// AXI package: write channel widths, fixed AW field values and the command register map
`default_nettype none

package hist_axi_pkg;

    localparam int axi_addr_w      = 32;
    localparam int axi_id_w        = 6;    // {sensor, sub-channel, color}
    localparam int burst_words     = 16;
    localparam int bursts_per_page = 16;

    localparam logic [3:0] axi_len   = 4'd15;   // 16 beats
    localparam logic [1:0] axi_size  = 2'd2;    // 4 bytes per beat
    localparam logic [1:0] axi_burst = 2'b01;   // incrementing
    localparam logic [3:0] axi_cache = 4'h3;
    localparam logic [2:0] axi_prot  = 3'h0;
    localparam logic [1:0] axi_lock  = 2'h0;
    localparam logic [3:0] axi_qos   = 4'h0;
    localparam logic [3:0] axi_strb  = 4'hf;    // all bytes

    localparam int start_page_w = 20;   // 4 KB page number
    localparam int cmd_addr_w   = 5;
    localparam int cmd_data_w   = 32;
    localparam logic [cmd_addr_w-1:0] reg_mode_addr = 5'd16;  // start page table sits below
    localparam int mode_en_bit  = 0;

endpackage

`default_nettype wire

// ==== hist_buf_pkg.sv ====
// histogram buffer package: sensor, page and attribute geometry plus the sender FSM states
`default_nettype none

package hist_buf_pkg;

    localparam int num_sensors = 4;   // sensor ports
    localparam int sensor_w    = 2;   // sensor index
    localparam int sub_chn_w   = 2;   // histogram sub-channel
    localparam int frame_w     = 4;   // frame number bits
    localparam int color_w     = 2;   // four colors per histogram
    localparam int page_w      = 2;   // buffer page index
    localparam int word_w      = 8;   // 256 words per page
    localparam int num_pages   = 4;
    localparam int data_w      = 32;

    // attribute layout, msb first: {sensor, sub-channel, frame, color}
    localparam int attr_w = sensor_w + sub_chn_w + frame_w + color_w;

    typedef enum logic [2:0] {
        send_idle,    // waiting for a complete page
        send_load,    // start page table lookup
        send_addr,    // page base address
        send_run,     // aw bursts and w data
        send_drain    // waiting for the last write responses
    } sender_state_t;

endpackage

`default_nettype wire

// ==== hist_page_buffer.sv ====
// histogram page buffer: four RAM pages with attributes and a small prefetch FIFO toward AXI
`timescale 1ns/1ps
`default_nettype none

module hist_page_buffer (
    input  wire                                mclk,
    input  wire                                rst,
    input  wire                                en,
    input  wire                                wr_en,
    input  wire  [hist_buf_pkg::page_w-1:0]    wr_page,
    input  wire  [hist_buf_pkg::word_w-1:0]    wr_word,
    input  wire  [hist_buf_pkg::data_w-1:0]    wr_data,
    input  wire                                page_done,
    input  wire  [hist_buf_pkg::attr_w-1:0]    page_attr,
    input  wire                                fifo_pop,
    input  wire                                page_release,
    output logic                               buf_full,
    output logic                               head_valid,
    output logic [hist_buf_pkg::attr_w-1:0]    head_attr,
    output logic [hist_buf_pkg::data_w-1:0]    fifo_data,
    output logic                               fifo_nempty
);
    import hist_buf_pkg::*;

    logic [data_w-1:0] ram [num_pages << word_w];   // 1024 x 32
    logic [attr_w-1:0] attr_mem [num_pages];
    logic [page_w:0]   pages;       // occupied pages, 0..4
    logic [page_w-1:0] rd_page;     // head page
    logic [word_w-1:0] rd_word;
    logic              rd_done;     // all 256 words fetched
    logic              re_w;
    logic              re_d1;
    logic              re_d2;       // fifo write
    logic [data_w-1:0] rd_q;
    logic [data_w-1:0] rd_q2;
    logic [data_w-1:0] fifo_mem [4];
    logic [1:0]        fifo_wp;
    logic [1:0]        fifo_rp;
    logic [2:0]        fifo_cnt;

    assign buf_full    = pages == (page_w + 1)'(num_pages);
    assign head_valid  = pages != '0;
    assign head_attr   = attr_mem[rd_page];
    assign fifo_data   = fifo_mem[fifo_rp];
    assign fifo_nempty = fifo_cnt != '0;
    // words in the FIFO plus those still in the RAM pipeline never exceed its depth
    assign re_w = en && head_valid && !rd_done && ({1'b0, fifo_cnt} + re_d1 + re_d2 < 4'd4);

    always_ff @(posedge mclk) begin
        if (wr_en) ram[{wr_page, wr_word}] <= wr_data;
        if (page_done) attr_mem[wr_page] <= page_attr;
        if (re_w) rd_q <= ram[{rd_page, rd_word}];  // stage 1
        if (re_d1) rd_q2 <= rd_q;                    // stage 2
        if (re_d2) fifo_mem[fifo_wp] <= rd_q2;
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            pages    <= '0;
            rd_page  <= '0;
            rd_word  <= '0;
            rd_done  <= 1'b0;
            re_d1    <= 1'b0;
            re_d2    <= 1'b0;
            fifo_wp  <= '0;
            fifo_rp  <= '0;
            fifo_cnt <= '0;
        end else begin
            pages    <= !en ? '0 : pages + page_done - page_release;
            rd_page  <= !en ? '0 : rd_page + page_release;
            rd_word  <= !en ? '0 : rd_word + re_w;            // wraps to 0 for next page
            re_d1    <= re_w;
            re_d2    <= en && re_d1;
            fifo_wp  <= !en ? '0 : fifo_wp + re_d2;
            fifo_rp  <= !en ? '0 : fifo_rp + fifo_pop;
            fifo_cnt <= !en ? '0 : fifo_cnt + re_d2 - fifo_pop;
            if (!en || page_release) rd_done <= 1'b0;         // pause until the page is freed
            else if (re_w && (&rd_word)) rd_done <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== hist_page_writer.sv ====
// histogram page writer: arbitrates the sensors, grants one and writes its four colors into pages
`timescale 1ns/1ps
`default_nettype none

module hist_page_writer (
    input  wire                                   mclk,
    input  wire                                   rst,
    input  wire                                   en,
    input  wire  [hist_buf_pkg::num_sensors-1:0]  hist_request,
    input  wire  [hist_buf_pkg::frame_w-1:0]      frame [hist_buf_pkg::num_sensors],
    input  wire  [hist_buf_pkg::sub_chn_w-1:0]    hist_chn [hist_buf_pkg::num_sensors],
    input  wire  [hist_buf_pkg::num_sensors-1:0]  hist_dvalid,
    input  wire  [hist_buf_pkg::data_w-1:0]       hist_data [hist_buf_pkg::num_sensors],
    input  wire                                   buf_full,
    output logic [hist_buf_pkg::num_sensors-1:0]  hist_grant,
    output logic                                  wr_en,
    output logic [hist_buf_pkg::page_w-1:0]       wr_page,
    output logic [hist_buf_pkg::word_w-1:0]       wr_word,
    output logic [hist_buf_pkg::data_w-1:0]       wr_data,
    output logic                                  page_done,
    output logic [hist_buf_pkg::attr_w-1:0]       page_attr
);
    import hist_buf_pkg::*;

    logic                 busy;      // one sensor owns the buffer for four colors
    logic [sensor_w-1:0]  sel;       // selected sensor
    logic [sensor_w-1:0]  pick;      // lowest active request
    logic                 dav;       // selected dvalid
    logic                 dav_r;
    logic                 done_w;    // falling edge of dvalid, color complete
    logic                 grant_r;
    logic [color_w-1:0]   color;
    logic [sub_chn_w-1:0] chn_r;
    logic [frame_w-1:0]   frame_r;

    always_comb begin
        pick = '0;
        for (int i = num_sensors - 1; i >= 0; i--) begin
            if (hist_request[i]) pick = sensor_w'(i);   // lower index overrides
        end
    end

    assign dav       = busy && hist_dvalid[sel];
    assign done_w    = dav_r && !dav;
    assign wr_en     = dav_r;
    assign page_attr = {sel, chn_r, frame_r, color};  // color advances on page_done

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy       <= 1'b0;
            sel        <= '0;
            dav_r      <= 1'b0;
            grant_r    <= 1'b0;
            hist_grant <= '0;
            page_done  <= 1'b0;
            color      <= '0;
            wr_page    <= '0;
            wr_word    <= '0;
        end else begin
            busy  <= en && (busy ? !(page_done && (&color)) : (|hist_request));
            dav_r <= en && dav;
            if (!busy) sel <= pick;                        // held while busy
            // no grant while a page count update is still in flight
            grant_r    <= en && busy && hist_request[sel] && !buf_full && !done_w && !page_done;
            hist_grant <= (en && grant_r && !done_w) ? num_sensors'(1'b1) << sel : '0;
            page_done  <= en && done_w;
            color      <= !en ? '0 : color + page_done;
            wr_page    <= !en ? '0 : wr_page + page_done;
            wr_word    <= dav_r ? wr_word + 1'b1 : '0;     // restarts every color
        end
    end

    always_ff @(posedge mclk) begin
        wr_data <= hist_data[sel];
        if (dav && !dav_r) begin                           // first word of a color
            chn_r   <= hist_chn[sel];
            frame_r <= frame[sel];
        end
    end

endmodule

`default_nettype wire

// ==== hist_saxi.sv ====
// histogram transfer top: mode register, sensor page writer, page buffer and AXI sender
`timescale 1ns/1ps
`default_nettype none

module hist_saxi (
    input  wire                                   mclk,
    input  wire                                   rst,
    input  wire                                   cmd_we,
    input  wire  [hist_axi_pkg::cmd_addr_w-1:0]   cmd_addr,
    input  wire  [hist_axi_pkg::cmd_data_w-1:0]   cmd_data,
    input  wire  [hist_buf_pkg::num_sensors-1:0]  hist_request,
    input  wire  [hist_buf_pkg::frame_w-1:0]      frame [hist_buf_pkg::num_sensors],
    input  wire  [hist_buf_pkg::sub_chn_w-1:0]    hist_chn [hist_buf_pkg::num_sensors],
    input  wire  [hist_buf_pkg::num_sensors-1:0]  hist_dvalid,
    input  wire  [hist_buf_pkg::data_w-1:0]       hist_data [hist_buf_pkg::num_sensors],
    output logic [hist_buf_pkg::num_sensors-1:0]  hist_grant,
    output logic [hist_axi_pkg::axi_addr_w-1:0]   saxi_awaddr,
    output logic                                  saxi_awvalid,
    input  wire                                   saxi_awready,
    output logic [hist_axi_pkg::axi_id_w-1:0]     saxi_awid,
    output logic [3:0]                            saxi_awlen,
    output logic [1:0]                            saxi_awsize,
    output logic [1:0]                            saxi_awburst,
    output logic [3:0]                            saxi_awcache,
    output logic [2:0]                            saxi_awprot,
    output logic [1:0]                            saxi_awlock,
    output logic [3:0]                            saxi_awqos,
    output logic [hist_buf_pkg::data_w-1:0]       saxi_wdata,
    output logic                                  saxi_wvalid,
    input  wire                                   saxi_wready,
    output logic [hist_axi_pkg::axi_id_w-1:0]     saxi_wid,
    output logic                                  saxi_wlast,
    output logic [3:0]                            saxi_wstrb,
    input  wire                                   saxi_bvalid,
    output logic                                  saxi_bready
);
    import hist_buf_pkg::*;
    import hist_axi_pkg::*;

    logic              en;            // mode register enable bit
    logic              wr_en;
    logic [page_w-1:0] wr_page;
    logic [word_w-1:0] wr_word;
    logic [data_w-1:0] wr_data;
    logic              page_done;
    logic [attr_w-1:0] page_attr;
    logic              buf_full;
    logic              head_valid;
    logic [attr_w-1:0] head_attr;
    logic [data_w-1:0] fifo_data;
    logic              fifo_nempty;
    logic              fifo_pop;
    logic              page_release;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) en <= 1'b0;
        else if (cmd_we && cmd_addr == reg_mode_addr) en <= cmd_data[mode_en_bit];
    end

    hist_page_writer i_writer (.*);   // sensor side
    hist_page_buffer i_buffer (.*);
    hist_saxi_sender i_sender (.*);   // AXI side, also takes the start page writes

endmodule

`default_nettype wire

// ==== hist_saxi_sender.sv ====
// histogram AXI sender: start page table, page address and AW/W/B channel control
`timescale 1ns/1ps
`default_nettype none

module hist_saxi_sender (
    input  wire                                   mclk,
    input  wire                                   rst,
    input  wire                                   en,
    input  wire                                   cmd_we,
    input  wire  [hist_axi_pkg::cmd_addr_w-1:0]   cmd_addr,
    input  wire  [hist_axi_pkg::cmd_data_w-1:0]   cmd_data,
    input  wire                                   head_valid,
    input  wire  [hist_buf_pkg::attr_w-1:0]       head_attr,
    input  wire  [hist_buf_pkg::data_w-1:0]       fifo_data,
    input  wire                                   fifo_nempty,
    input  wire                                   saxi_awready,
    input  wire                                   saxi_wready,
    input  wire                                   saxi_bvalid,
    output logic                                  page_release,
    output logic                                  fifo_pop,
    output logic [hist_axi_pkg::axi_addr_w-1:0]   saxi_awaddr,
    output logic                                  saxi_awvalid,
    output logic [hist_axi_pkg::axi_id_w-1:0]     saxi_awid,
    output logic [3:0]                            saxi_awlen,
    output logic [1:0]                            saxi_awsize,
    output logic [1:0]                            saxi_awburst,
    output logic [3:0]                            saxi_awcache,
    output logic [2:0]                            saxi_awprot,
    output logic [1:0]                            saxi_awlock,
    output logic [3:0]                            saxi_awqos,
    output logic [hist_buf_pkg::data_w-1:0]       saxi_wdata,
    output logic                                  saxi_wvalid,
    output logic [hist_axi_pkg::axi_id_w-1:0]     saxi_wid,
    output logic                                  saxi_wlast,
    output logic [3:0]                            saxi_wstrb,
    output logic                                  saxi_bready
);
    import hist_buf_pkg::*;
    import hist_axi_pkg::*;

    logic [start_page_w-1:0]       start_tab [1 << (sensor_w + sub_chn_w)];
    sender_state_t                 state;
    logic [attr_w-1:0]             attr_r;      // attribute of the page in flight
    logic [start_page_w-1:0]       sp_r;
    logic [sensor_w+sub_chn_w-1:0] tab_idx;     // {sensor, sub-channel}
    logic [frame_w-1:0]            attr_frame;
    logic [color_w-1:0]            attr_color;
    logic [4:0]                    aw_cnt;      // accepted AW bursts
    logic [4:0]                    wb_cnt;      // completed W bursts
    logic [4:0]                    b_cnt;       // write responses
    logic [3:0]                    w_cnt;       // beat within a burst

    assign tab_idx    = attr_r[attr_w-1 -: sensor_w + sub_chn_w];
    assign attr_frame = attr_r[color_w +: frame_w];
    assign attr_color = attr_r[color_w-1:0];

    assign saxi_awid    = {tab_idx, attr_color};
    assign saxi_wid     = {tab_idx, attr_color};
    assign saxi_awlen   = axi_len;
    assign saxi_awsize  = axi_size;
    assign saxi_awburst = axi_burst;
    assign saxi_awcache = axi_cache;
    assign saxi_awprot  = axi_prot;
    assign saxi_awlock  = axi_lock;
    assign saxi_awqos   = axi_qos;
    assign saxi_wstrb   = axi_strb;
    assign saxi_bready  = 1'b1;
    assign saxi_wdata   = fifo_data;
    assign saxi_wlast   = &w_cnt;
    // W never runs ahead of its AW burst
    assign saxi_wvalid  = (state == send_run) && (wb_cnt < aw_cnt) && fifo_nempty;
    assign fifo_pop     = saxi_wvalid && saxi_wready;

    always_ff @(posedge mclk) begin
        if (cmd_we && cmd_addr < reg_mode_addr) begin
            start_tab[cmd_addr[sensor_w+sub_chn_w-1:0]] <= cmd_data[start_page_w-1:0];
        end
        if (state == send_idle) attr_r <= head_attr;
        if (state == send_load) sp_r <= start_tab[tab_idx];
        if (state == send_addr) begin
            // 4 KB page from start page plus frame, color picks the 1 KB quarter
            saxi_awaddr <= {sp_r + start_page_w'(attr_frame), attr_color, 10'b0};
        end else if (saxi_awvalid && saxi_awready) begin
            saxi_awaddr <= saxi_awaddr + axi_addr_w'(burst_words * 4);
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state        <= send_idle;
            saxi_awvalid <= 1'b0;
            page_release <= 1'b0;
            aw_cnt       <= '0;
            wb_cnt       <= '0;
            b_cnt        <= '0;
            w_cnt        <= '0;
        end else begin
            page_release <= 1'b0;
            if (saxi_awvalid && saxi_awready) aw_cnt <= aw_cnt + 1'b1;
            if (fifo_pop) w_cnt <= w_cnt + 1'b1;
            if (fifo_pop && saxi_wlast) wb_cnt <= wb_cnt + 1'b1;
            if (saxi_bvalid) b_cnt <= b_cnt + 1'b1;
            case (state)
                send_idle: begin
                    if (head_valid && !page_release) state <= send_load;  // count not yet updated
                end
                send_load: state <= send_addr;
                send_addr: begin
                    aw_cnt       <= '0;
                    wb_cnt       <= '0;
                    b_cnt        <= '0;
                    w_cnt        <= '0;
                    saxi_awvalid <= 1'b1;
                    state        <= send_run;
                end
                send_run: begin
                    if (saxi_awvalid && saxi_awready && aw_cnt == 5'(bursts_per_page - 1)) begin
                        saxi_awvalid <= 1'b0;                           // last AW of the page
                    end
                    if (wb_cnt == 5'(bursts_per_page)) state <= send_drain;
                end
                send_drain: begin
                    if (b_cnt == 5'(bursts_per_page)) begin
                        page_release <= 1'b1;
                        state        <= send_idle;
                    end
                end
                default: state <= send_idle;
            endcase
            if (!en) begin
                state        <= send_idle;
                saxi_awvalid <= 1'b0;
                page_release <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+.
hist_buf_pkg.sv
hist_axi_pkg.sv
hist_page_writer.sv
hist_page_buffer.sv
hist_saxi_sender.sv
hist_saxi.sv
tb_hist_saxi.sv

// ==== tb_hist_model.svh ====
// histogram testbench model: LFSR stimulus bits, reference word and address, value check
`ifndef TB_HIST_MODEL_SVH
`define TB_HIST_MODEL_SVH

logic [31:0] lfsr_state = 32'hb2729a54;

// fibonacci LFSR, taps 32 22 2 1, one step per bit
function automatic logic next_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
endfunction

function automatic logic [19:0] start_of(input logic [3:0] idx);
    return 20'h00200 + 20'(idx) * 20'h11;   // start page table contents
endfunction

function automatic logic [31:0] make_word(input logic [1:0] s, input logic [1:0] chn,
                                          input logic [1:0] c, input logic [7:0] w);
    return {6'b0, s, 6'b0, chn, 6'b0, c, w};   // sensor, sub-channel, color, word
endfunction

// 4 KB page from start page plus frame, 1 KB quarter per color, 4 bytes per word
function automatic logic [31:0] ref_addr(input logic [19:0] sp, input logic [3:0] fr,
                                         input logic [1:0] c, input logic [7:0] w);
    return ((32'(sp) + 32'(fr)) << 12) + (32'(c) << 10) + (32'(w) << 2);
endfunction

task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1);
endtask

task automatic stop_run(input string msg);
    $display("error at %0t: %s", $time, msg);
    abort_run();
endtask

task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        abort_run();
    end
endtask

`endif

// ==== tb_hist_saxi.sv ====
// histogram transfer testbench: sensor drivers, AXI write slave model and word comparison
`timescale 1ns/1ps
`default_nettype none

module tb_hist_saxi;
    import hist_buf_pkg::*;
    import hist_axi_pkg::*;

    logic                   mclk = 1'b0;
    logic                   rst;
    logic                   cmd_we;
    logic [cmd_addr_w-1:0]  cmd_addr;
    logic [cmd_data_w-1:0]  cmd_data;
    logic [num_sensors-1:0] hist_request;
    logic [frame_w-1:0]     frame [num_sensors];
    logic [sub_chn_w-1:0]   hist_chn [num_sensors];
    logic [num_sensors-1:0] hist_dvalid;
    logic [data_w-1:0]      hist_data [num_sensors];
    logic [num_sensors-1:0] hist_grant;
    logic [axi_addr_w-1:0]  saxi_awaddr;
    logic                   saxi_awvalid;
    logic                   saxi_awready;
    logic [axi_id_w-1:0]    saxi_awid;
    logic [3:0]             saxi_awlen;
    logic [1:0]             saxi_awsize;
    logic [1:0]             saxi_awburst;
    logic [3:0]             saxi_awcache;
    logic [2:0]             saxi_awprot;
    logic [1:0]             saxi_awlock;
    logic [3:0]             saxi_awqos;
    logic [data_w-1:0]      saxi_wdata;
    logic                   saxi_wvalid;
    logic                   saxi_wready;
    logic [axi_id_w-1:0]    saxi_wid;
    logic                   saxi_wlast;
    logic [3:0]             saxi_wstrb;
    logic                   saxi_bvalid;
    logic                   saxi_bready;

    logic [1:0]             exp_sens [$];   // histograms in expected service order
    logic [31:0]            aw_q [$];       // accepted burst addresses waiting for W
    logic [31:0]            cur_addr;
    int                     aw_n = 0;
    int                     w_n = 0;
    int                     beat = 0;
    int                     b_pending = 0;

    `include "tb_hist_model.svh"

    hist_saxi i_hist_saxi (.*);

    always #5 mclk = ~mclk;

    task automatic write_cmd(input logic [4:0] a, input logic [31:0] d);
        cmd_we   = 1'b1;
        cmd_addr = a;
        cmd_data = d;
        @(negedge mclk);
        cmd_we   = 1'b0;
    endtask

    task automatic set_ids();
        for (int s = 0; s < num_sensors; s++) begin
            hist_chn[s] = {next_bit(), next_bit()};
            frame[s]    = {next_bit(), next_bit(), next_bit(), next_bit()};
        end
    endtask

    // one sensor: request, then four colors of 256 words, each after a fresh grant
    task automatic run_sensor(input int s);
        int t;
        hist_request[s] = 1'b1;
        for (int c = 0; c < 4; c++) begin
            t = 0;
            while (!hist_grant[s]) begin
                t++;
                if (t > 60000) stop_run("sensor grant never came");
                @(negedge mclk);
            end
            for (int w = 0; w < 256; w++) begin
                hist_dvalid[s] = 1'b1;
                hist_data[s]   = make_word(2'(s), hist_chn[s], 2'(c), 8'(w));
                @(negedge mclk);
            end
            hist_dvalid[s] = 1'b0;
            if (c == 3) hist_request[s] = 1'b0;   // done before the grant can return
            t = 0;
            while (hist_grant[s]) begin
                t++;
                if (t > 100) stop_run("grant stayed high after a color");
                @(negedge mclk);
            end
        end
    endtask

    task automatic check_aw();
        int         h;
        int         c;
        int         b;
        logic [1:0] s;
        h = aw_n >> 6;
        c = (aw_n >> 4) & 3;
        b = aw_n & 15;
        if (h >= exp_sens.size()) stop_run("unexpected AW burst");
        s = exp_sens[h];
        check("awaddr", saxi_awaddr,
              ref_addr(start_of({s, hist_chn[s]}), frame[s], 2'(c), 8'(b * 16)));
        check("awid", 32'(saxi_awid), 32'({s, hist_chn[s], 2'(c)}));
        check("aw fields", 32'({saxi_awlen, saxi_awsize, saxi_awburst, saxi_awcache,
                                saxi_awprot, saxi_awlock, saxi_awqos}),
              32'({axi_len, axi_size, axi_burst, axi_cache, axi_prot, axi_lock, axi_qos}));
        aw_q.push_back(saxi_awaddr);
        aw_n++;
    endtask

    task automatic check_w();
        int         h;
        int         c;
        int         w;
        logic [1:0] s;
        h = w_n >> 10;
        c = (w_n >> 8) & 3;
        w = w_n & 255;
        if (h >= exp_sens.size()) stop_run("unexpected W word");
        s = exp_sens[h];
        if (beat == 0) begin
            if (aw_q.size() == 0) stop_run("W burst without an accepted AW");
            cur_addr = aw_q.pop_front();
        end
        check("waddr", cur_addr + 32'(beat * 4),
              ref_addr(start_of({s, hist_chn[s]}), frame[s], 2'(c), 8'(w)));
        check("wdata", saxi_wdata, make_word(s, hist_chn[s], 2'(c), 8'(w)));
        check("wid", 32'(saxi_wid), 32'({s, hist_chn[s], 2'(c)}));
        check("wlast", 32'(saxi_wlast), 32'(beat == 15));
        check("wstrb", 32'(saxi_wstrb), 32'(axi_strb));
        if (saxi_wlast) b_pending++;
        beat = (beat + 1) % 16;
        w_n++;
    endtask

    // AXI slave model: handshakes seen here complete on the next rising edge
    always @(negedge mclk) begin
        if (!rst) begin
            if ($countones(hist_grant) > 1) stop_run("more than one grant at a time");
            check("bready", 32'(saxi_bready), 32'(1'b1));
            if (b_pending > 0 && next_bit()) begin   // random response delay
                saxi_bvalid = 1'b1;
                b_pending--;
            end else begin
                saxi_bvalid = 1'b0;
            end
            saxi_awready = next_bit() | next_bit();
            saxi_wready  = next_bit() | next_bit();
            if (saxi_awvalid && saxi_awready) check_aw();
            if (saxi_wvalid && saxi_wready) check_w();
        end
    end

    task automatic wait_drained();
        int t;
        t = 0;
        while (w_n != exp_sens.size() * 1024 || b_pending != 0 || saxi_bvalid) begin
            t++;
            if (t > 100000) stop_run("transfer did not finish");
            @(negedge mclk);
        end
    endtask

    initial begin
        rst          = 1'b1;
        cmd_we       = 1'b0;
        cmd_addr     = '0;
        cmd_data     = '0;
        hist_request = '0;
        hist_dvalid  = '0;
        saxi_awready = 1'b0;
        saxi_wready  = 1'b0;
        saxi_bvalid  = 1'b0;
        for (int s = 0; s < num_sensors; s++) begin
            frame[s]     = '0;
            hist_chn[s]  = '0;
            hist_data[s] = '0;
        end
        repeat (5) @(posedge mclk);
        @(negedge mclk);
        rst = 1'b0;
        for (int i = 0; i < 16; i++) write_cmd(5'(i), 32'(start_of(4'(i))));
        set_ids();
        exp_sens.push_back(2'd0);
        fork
            run_sensor(0);
            begin
                repeat (50) begin   // en still low, nothing may move
                    @(negedge mclk);
                    if (|hist_grant || saxi_awvalid || saxi_wvalid)
                        stop_run("activity while disabled");
                end
                write_cmd(reg_mode_addr, 32'(1) << mode_en_bit);
            end
        join
        wait_drained();
        set_ids();
        for (int s = 0; s < num_sensors; s++) exp_sens.push_back(2'(s));   // lowest index first
        fork
            run_sensor(0);
            run_sensor(1);
            run_sensor(2);
            run_sensor(3);
        join
        wait_drained();
        if (w_n == exp_sens.size() * 1024 && aw_n == exp_sens.size() * 64) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_run("word or burst count is short");
        end
    end

endmodule

`default_nettype wire
